/* mac_align.sv */
// stage 1: max exponent search and product alignment
// two's complement terms shifted to the shared exponent
`default_nettype none

`include "mac_lane_params.svh"

module mac_align (
    input  logic                                            i_clk,
    input  logic                                            i_en,
    input  mac_fmt_pkg::mac_dtype_e                         i_dtype,
    input  logic [`MAC_N_ELEM-1:0]                          i_live,
    input  logic [`MAC_N_ELEM-1:0]                          i_neg,
    input  logic [`MAC_N_ELEM-1:0][`MAC_W_PROD-1:0]         i_mag,
    input  mac_fmt_pkg::mac_pexp_t [`MAC_N_ELEM-1:0]        i_pexp,
    output logic signed [`MAC_N_ELEM-1:0][`MAC_W_SUM-1:0]   o_term,
    output mac_fmt_pkg::mac_pexp_t                          o_max_exp,
    output mac_fmt_pkg::mac_dtype_e                         o_dtype
);

    localparam int              W_SH   = $clog2(`MAC_MAX_SHIFT + 1);
    localparam logic [W_SH-1:0] SH_CAP = `MAC_MAX_SHIFT;

    mac_fmt_pkg::mac_pexp_t                         max_exp;
    logic signed [`MAC_N_ELEM-1:0][`MAC_W_SUM-1:0]  term;

    // dead elements never set the exponent
    always_comb begin : find_max
        max_exp = '0;
        for (int i = 0; i < `MAC_N_ELEM; i++) begin
            if (i_live[i] && (i_pexp[i] > max_exp)) begin
                max_exp = i_pexp[i];
            end
        end
        if (i_dtype != mac_fmt_pkg::DT_FP8) begin
            max_exp = '0;
        end
    end

    for (genvar i = 0; i < `MAC_N_ELEM; i++) begin : g_term
        mac_fmt_pkg::mac_pexp_t     diff;
        logic [W_SH-1:0]            shamt;
        logic signed [`MAC_W_SUM-1:0] mag_ext;
        logic signed [`MAC_W_SUM-1:0] val;
        logic signed [`MAC_W_SUM-1:0] t;

        assign diff    = max_exp - i_pexp[i];
        assign shamt   = (diff > SH_CAP) ? SH_CAP : diff[W_SH-1:0];  // clamp
        assign mag_ext = {{(`MAC_W_SUM - `MAC_W_PROD){1'b0}}, i_mag[i]};
        assign val     = i_neg[i] ? -mag_ext : mag_ext;

        always_comb begin
            if (!i_live[i]) begin
                t = '0;
            end else if (i_dtype == mac_fmt_pkg::DT_I9) begin
                t = val;
            end else begin
                t = val >>> shamt;  // floors negative terms
            end
        end

        assign term[i] = t;
    end

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            o_term    <= term;
            o_max_exp <= max_exp;
            o_dtype   <= i_dtype;
        end
    end

endmodule

`default_nettype wire

/* mac_ctrl_pkg.sv */
// flow-control state types
// output FIFO fill state
`default_nettype none

package mac_ctrl_pkg;

    typedef enum logic [1:0] {
        FILL_EMPTY = 2'd0,
        FILL_ONE   = 2'd1,
        FILL_FULL  = 2'd2
    } fifo_fill_e;

endpackage

`default_nettype wire

/* mac_fmt_pkg.sv */
// number format types of the dot-product lane
// datatype select, element layout, product exponent
`default_nettype none

`include "mac_lane_params.svh"

package mac_fmt_pkg;

    // one datatype for both operands
    typedef enum logic {
        DT_I9  = 1'b0,  // sign-magnitude integer
        DT_FP8 = 1'b1   // sign, 4b exp, 4b mant, no hidden bit
    } mac_dtype_e;

    // one element as it arrives on the input bus
    typedef struct packed {
        logic                     zero;  // explicit zero
        logic                     sign;
        logic [`MAC_W_ELEM-3:0]   body;  // magnitude or exp/mant
    } mac_elem_t;

    // fp8 view of the element body
    typedef struct packed {
        logic [`MAC_W_EXP-1:0]               exp;
        logic [`MAC_W_MANT-`MAC_W_EXP-1:0]   mant;
    } mac_fp8_field_t;

    typedef logic [`MAC_W_EXP:0] mac_pexp_t;  // sum of two exps

endpackage

`default_nettype wire

/* mac_lane.f */
+incdir+.
mac_fmt_pkg.sv
mac_ctrl_pkg.sv
pipe_ctrl.sv
mac_product.sv
mac_align.sv
mac_sum_tree.sv
mac_out_fifo.sv
mac_lane_top.sv
tb_mac_lane.sv

/* mac_lane_params.svh */
// size and width constants of the dot-product lane
// element, product, sum and pipeline geometry
`ifndef MAC_LANE_PARAMS_SVH
`define MAC_LANE_PARAMS_SVH

////////////////////////////////////////////////////////////
// element geometry
`define MAC_N_ELEM      8   // element pairs per beat
`define MAC_W_ELEM      10  // zero flag + sign + 8 body bits
`define MAC_W_EXP       4   // fp8 exponent
`define MAC_W_MANT      8   // i9 magnitude, or fp8 exp/mant pair

////////////////////////////////////////////////////////////
// datapath
`define MAC_W_PROD      16  // product magnitude
`define MAC_GUARD       4   // guard bits below an fp8 product
`define MAC_MAX_SHIFT   15  // alignment shift cap
`define MAC_W_SUM       22  // signed sum

// flow control
`define MAC_N_STAGE     3
`define MAC_FIFO_DEPTH  2

`endif

/* mac_lane_patterns.txt */
// dtype mask  act0..act7  wgt0..wgt7  expected_sum expected_exp, all hex
// element = zero flag, sign, 8 body bits; sum is 22-bit two's complement
0 ff  001 002 003 004 005 006 007 008  001 001 001 001 001 001 001 001  000024 00
0 ff  0ff 1ff 010 103 064 000 000 000  0ff 0ff 120 105 007 000 000 000  0000cb 00
1 ff  012 012 012 012 012 012 012 012  013 013 013 013 013 013 013 013  000300 02
1 0f  035 013 007 02f 0ff 000 000 000  024 012 001 02f 0ff 000 000 000  000857 05
0 ff  0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff  0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff  07f008 00
1 0f  041 113 105 122 000 000 000 000  041 011 103 023 000 000 000 000  000009 08
0 ff  1ff 1ff 1ff 1ff 1ff 1ff 1ff 1ff  0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff  380ff8 00
1 07  0ff 111 18f 000 000 000 000 000  0f1 001 07f 000 000 000 000 000  0000ee 1e
0 0f  00a 00a 00a 00a 0ff 0ff 0ff 0ff  002 002 002 002 002 002 002 002  000050 00
1 ff  2ff 033 021 012 000 000 000 000  0ff 032 3ff 022 000 000 000 000  000068 06
0 ff  2ff 005 007 103 000 000 000 000  0ff 006 30a 004 000 000 000 000  000012 00
1 ff  200 200 200 200 200 200 200 200  0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff  000000 00
0 00  0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff  0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff  000000 00
1 00  0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff  0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff  000000 00
1 ff  028 134 00f 022 047 106 113 011  013 015 00f 122 001 105 003 011  0000a1 04
0 ff  1c8 032 000 000 000 000 000 000  096 064 000 000 000 000 000 000  3f9e58 00
1 0f  1ff 1ef 1e1 1e3 000 000 000 000  0ff 0ff 0e1 0b1 000 000 000 000  3feae2 1e
0 ff  011 122 033 044 155 066 077 188  002 003 104 005 006 107 008 009  3ffa6c 00

/* mac_lane_top.sv */
// eight-element dot-product lane
// pipeline control, three datapath stages and output FIFO
`default_nettype none

`include "mac_lane_params.svh"

module mac_lane_top (
    input  logic                                        i_clk,
    input  logic                                        i_reset,
    input  logic                                        i_in_valid,
    output logic                                        o_in_ready,
    input  mac_fmt_pkg::mac_dtype_e                     i_dtype,
    input  logic [`MAC_N_ELEM-1:0]                      i_mask,
    input  logic [`MAC_N_ELEM*`MAC_W_ELEM-1:0]          i_act,
    input  logic [`MAC_N_ELEM*`MAC_W_ELEM-1:0]          i_wgt,
    output logic                                        o_out_valid,
    input  logic                                        i_out_ready,
    output logic signed [`MAC_W_SUM-1:0]                o_sum,
    output mac_fmt_pkg::mac_pexp_t                      o_exp
);

    logic [`MAC_N_STAGE-1:0]                        stage_en;
    logic                                           pipe_valid;
    logic                                           fifo_ready;

    // stage 0 -> 1
    logic [`MAC_N_ELEM-1:0]                         p_live;
    logic [`MAC_N_ELEM-1:0]                         p_neg;
    logic [`MAC_N_ELEM-1:0][`MAC_W_PROD-1:0]        p_mag;
    mac_fmt_pkg::mac_pexp_t [`MAC_N_ELEM-1:0]       p_pexp;
    mac_fmt_pkg::mac_dtype_e                        p_dtype;

    // stage 1 -> 2
    logic signed [`MAC_N_ELEM-1:0][`MAC_W_SUM-1:0]  a_term;
    mac_fmt_pkg::mac_pexp_t                         a_max_exp;
    mac_fmt_pkg::mac_dtype_e                        a_dtype;

    // stage 2 -> fifo
    logic signed [`MAC_W_SUM-1:0]                   s_sum;
    mac_fmt_pkg::mac_pexp_t                         s_exp;

    pipe_ctrl u_pipe_ctrl (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_in_valid   (i_in_valid),
        .i_out_ready  (fifo_ready),
        .o_in_ready   (o_in_ready),
        .o_pipe_valid (pipe_valid),
        .o_stage_en   (stage_en)
    );

    mac_product u_mac_product (
        .i_clk   (i_clk),      .i_en    (stage_en[0]), .i_dtype (i_dtype),
        .i_mask  (i_mask),     .i_act   (i_act),       .i_wgt   (i_wgt),
        .o_live  (p_live),     .o_neg   (p_neg),       .o_mag   (p_mag),
        .o_pexp  (p_pexp),     .o_dtype (p_dtype)
    );

    mac_align u_mac_align (
        .i_clk   (i_clk),      .i_en    (stage_en[1]), .i_dtype (p_dtype),
        .i_live  (p_live),     .i_neg   (p_neg),       .i_mag   (p_mag),
        .i_pexp  (p_pexp),     .o_term  (a_term),      .o_max_exp (a_max_exp),
        .o_dtype (a_dtype)
    );

    mac_sum_tree u_mac_sum_tree (
        .i_clk     (i_clk),    .i_en      (stage_en[2]), .i_term (a_term),
        .i_max_exp (a_max_exp), .i_dtype  (a_dtype),
        .o_sum     (s_sum),    .o_exp     (s_exp)
    );

    mac_out_fifo u_mac_out_fifo (
        .i_clk       (i_clk),      .i_reset    (i_reset),
        .i_in_valid  (pipe_valid), .i_sum      (s_sum),     .i_exp (s_exp),
        .i_out_ready (i_out_ready), .o_in_ready (fifo_ready),
        .o_out_valid (o_out_valid), .o_sum     (o_sum),     .o_exp (o_exp)
    );

endmodule

`default_nettype wire

/* mac_out_fifo.sv */
// two-entry output FIFO for sum and exponent
// registered input ready cuts the ready path
`default_nettype none

`include "mac_lane_params.svh"

module mac_out_fifo (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_in_valid,
    input  logic signed [`MAC_W_SUM-1:0]    i_sum,
    input  mac_fmt_pkg::mac_pexp_t          i_exp,
    input  logic                            i_out_ready,
    output logic                            o_in_ready,
    output logic                            o_out_valid,
    output logic signed [`MAC_W_SUM-1:0]    o_sum,
    output mac_fmt_pkg::mac_pexp_t          o_exp
);

    localparam int W_PTR = $clog2(`MAC_FIFO_DEPTH);

    mac_ctrl_pkg::fifo_fill_e       fill;
    mac_ctrl_pkg::fifo_fill_e       fill_nxt;
    logic [W_PTR-1:0]               wr_ptr;
    logic [W_PTR-1:0]               rd_ptr;
    logic signed [`MAC_W_SUM-1:0]   mem_sum [`MAC_FIFO_DEPTH];
    mac_fmt_pkg::mac_pexp_t         mem_exp [`MAC_FIFO_DEPTH];
    logic                           push;
    logic                           pop;

    assign push        = i_in_valid & o_in_ready;
    assign pop         = o_out_valid & i_out_ready;
    assign o_out_valid = (fill != mac_ctrl_pkg::FILL_EMPTY);
    assign o_sum       = mem_sum[rd_ptr];
    assign o_exp       = mem_exp[rd_ptr];

    always_comb begin
        fill_nxt = fill;
        case (fill)
            mac_ctrl_pkg::FILL_EMPTY: if (push) fill_nxt = mac_ctrl_pkg::FILL_ONE;
            mac_ctrl_pkg::FILL_ONE: begin
                if (push && !pop) begin
                    fill_nxt = mac_ctrl_pkg::FILL_FULL;
                end else if (pop && !push) begin
                    fill_nxt = mac_ctrl_pkg::FILL_EMPTY;
                end
            end
            mac_ctrl_pkg::FILL_FULL: if (pop) fill_nxt = mac_ctrl_pkg::FILL_ONE;
            default: fill_nxt = mac_ctrl_pkg::FILL_EMPTY;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            fill       <= mac_ctrl_pkg::FILL_EMPTY;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            o_in_ready <= 1'b1;
        end else begin
            fill       <= fill_nxt;
            o_in_ready <= (fill_nxt != mac_ctrl_pkg::FILL_FULL);  // known a cycle early
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem_sum[wr_ptr] <= i_sum;
            mem_exp[wr_ptr] <= i_exp;
        end
    end

    // the registered ready must track the fill state
    a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_reset)
        push |-> (fill != mac_ctrl_pkg::FILL_FULL))
        else $error("push into a full output FIFO");

    // pointers must show a stored entry whenever one is taken
    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_reset)
        pop |-> ((wr_ptr != rd_ptr) || (fill == mac_ctrl_pkg::FILL_FULL)))
        else $error("pop from an empty output FIFO");

endmodule

`default_nettype wire

/* mac_product.sv */
// stage 0: element decode and pair multiply
// liveness, product sign, magnitude and exponent registered
`default_nettype none

`include "mac_lane_params.svh"

module mac_product (
    input  logic                                        i_clk,
    input  logic                                        i_en,
    input  mac_fmt_pkg::mac_dtype_e                     i_dtype,
    input  logic [`MAC_N_ELEM-1:0]                      i_mask,
    input  mac_fmt_pkg::mac_elem_t [`MAC_N_ELEM-1:0]    i_act,
    input  mac_fmt_pkg::mac_elem_t [`MAC_N_ELEM-1:0]    i_wgt,
    output logic [`MAC_N_ELEM-1:0]                      o_live,
    output logic [`MAC_N_ELEM-1:0]                      o_neg,
    output logic [`MAC_N_ELEM-1:0][`MAC_W_PROD-1:0]     o_mag,
    output mac_fmt_pkg::mac_pexp_t [`MAC_N_ELEM-1:0]    o_pexp,
    output mac_fmt_pkg::mac_dtype_e                     o_dtype
);

    localparam int W_FMANT = `MAC_W_MANT - `MAC_W_EXP;

    logic [`MAC_N_ELEM-1:0]                   live;
    logic [`MAC_N_ELEM-1:0]                   neg;
    logic [`MAC_N_ELEM-1:0][`MAC_W_PROD-1:0]  mag;
    mac_fmt_pkg::mac_pexp_t [`MAC_N_ELEM-1:0] pexp;

    for (genvar i = 0; i < `MAC_N_ELEM; i++) begin : g_elem
        mac_fmt_pkg::mac_fp8_field_t  a_fp;
        mac_fmt_pkg::mac_fp8_field_t  w_fp;
        logic [`MAC_W_MANT-1:0]       a_mag;
        logic [`MAC_W_MANT-1:0]       w_mag;
        logic [2*W_FMANT-1:0]         fp_prod;
        logic [`MAC_W_PROD-1:0]       e_mag;
        mac_fmt_pkg::mac_pexp_t       e_pexp;

        assign a_fp    = i_act[i].body;
        assign w_fp    = i_wgt[i].body;
        assign a_mag   = i_act[i].body;
        assign w_mag   = i_wgt[i].body;
        assign fp_prod = a_fp.mant * w_fp.mant;

        assign live[i] = i_mask[i] & ~i_act[i].zero & ~i_wgt[i].zero;
        assign neg[i]  = i_act[i].sign ^ i_wgt[i].sign;

        always_comb begin
            if (i_dtype == mac_fmt_pkg::DT_FP8) begin
                e_mag  = {{(`MAC_W_PROD - 2*W_FMANT){1'b0}}, fp_prod} << `MAC_GUARD;
                e_pexp = {1'b0, a_fp.exp} + {1'b0, w_fp.exp};
            end else begin
                e_mag  = a_mag * w_mag;  // full 16b integer product
                e_pexp = '0;
            end
        end

        assign mag[i]  = e_mag;
        assign pexp[i] = e_pexp;
    end

    ////////////////////////////////////////////////////////////
    // stage 0 registers
    always_ff @(posedge i_clk) begin
        if (i_en) begin
            o_live  <= live;
            o_neg   <= neg;
            o_mag   <= mag;
            o_pexp  <= pexp;
            o_dtype <= i_dtype;
        end
    end

endmodule

`default_nettype wire

/* mac_sum_tree.sv */
// stage 2: three-level adder tree over the aligned terms
// registered sum and shared exponent
`default_nettype none

`include "mac_lane_params.svh"

module mac_sum_tree (
    input  logic                                            i_clk,
    input  logic                                            i_en,
    input  logic signed [`MAC_N_ELEM-1:0][`MAC_W_SUM-1:0]   i_term,
    input  mac_fmt_pkg::mac_pexp_t                          i_max_exp,
    input  mac_fmt_pkg::mac_dtype_e                         i_dtype,
    output logic signed [`MAC_W_SUM-1:0]                    o_sum,
    output mac_fmt_pkg::mac_pexp_t                          o_exp
);

    logic signed [`MAC_W_SUM:0]   sum_l1 [`MAC_N_ELEM/2];
    logic signed [`MAC_W_SUM+1:0] sum_l2 [`MAC_N_ELEM/4];
    logic signed [`MAC_W_SUM+2:0] sum_l3;
    logic [3:0]                   top_bits;

    for (genvar g = 0; g < `MAC_N_ELEM/2; g++) begin : g_l1
        assign sum_l1[g] = $signed(i_term[2*g]) + $signed(i_term[2*g+1]);
    end

    for (genvar g = 0; g < `MAC_N_ELEM/4; g++) begin : g_l2
        assign sum_l2[g] = sum_l1[2*g] + sum_l1[2*g+1];
    end

    assign sum_l3   = sum_l2[0] + sum_l2[1];
    assign top_bits = sum_l3[`MAC_W_SUM+2:`MAC_W_SUM-1];  // growth bits + sign

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            o_sum <= sum_l3[`MAC_W_SUM-1:0];
            o_exp <= (i_dtype == mac_fmt_pkg::DT_FP8) ? i_max_exp : '0;
        end
    end

    // upstream ranges keep the total inside the output width
    a_no_ovf: assert property (@(posedge i_clk)
        i_en |-> ((top_bits == 4'b0000) || (top_bits == 4'b1111)))
        else $error("adder tree overflow, top bits %b", top_bits);

endmodule

`default_nettype wire

/* pipe_ctrl.sv */
// pipeline valid bits and stage enables
// back-pressure chained from the output FIFO ready
`default_nettype none

`include "mac_lane_params.svh"

module pipe_ctrl (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_in_valid,
    input  logic                       i_out_ready,
    output logic                       o_in_ready,
    output logic                       o_pipe_valid,
    output logic [`MAC_N_STAGE-1:0]    o_stage_en
);

    logic [`MAC_N_STAGE-1:0] stage_valid;
    logic [`MAC_N_STAGE-1:0] stage_room;   // empty, or emptying this cycle
    logic [`MAC_N_STAGE-1:0] src_valid;

    assign src_valid = {stage_valid[`MAC_N_STAGE-2:0], i_in_valid};

    // a full stage has room only if everything after it moves
    always_comb begin : room_chain
        logic room;
        room = i_out_ready;
        for (int k = `MAC_N_STAGE - 1; k >= 0; k--) begin
            room = ~stage_valid[k] | room;
            stage_room[k] = room;
        end
    end

    assign o_stage_en   = src_valid & stage_room;
    assign o_in_ready   = stage_room[0];
    assign o_pipe_valid = stage_valid[`MAC_N_STAGE-1];

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            stage_valid <= '0;
        end else begin
            stage_valid <= o_stage_en | (stage_valid & ~stage_room);  // load, hold or drain
        end
    end

    // data pulled into stage k must have been sitting in stage k-1
    for (genvar k = 1; k < `MAC_N_STAGE; k++) begin : g_chk
        a_en_src: assert property (@(posedge i_clk) disable iff (!i_reset)
            o_stage_en[k] |-> $past(o_stage_en[k-1] | (stage_valid[k-1] & ~stage_room[k-1])))
            else $error("stage %0d pulled an empty slot, out ready %b (fifo state %0d when low)",
                        k, i_out_ready, mac_ctrl_pkg::FILL_FULL);
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the dot-product lane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mac_lane -f mac_lane.f

./obj_dir/Vtb_mac_lane > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation passed" sim.log

/* tb_mac_lane.sv */
// testbench for the dot-product lane
// pattern file stimulus, random input gaps and output back-pressure
`default_nettype none

`include "mac_lane_params.svh"

module tb_mac_lane;

    localparam int N_VEC       = 18;
    localparam int N_WORD      = 20;  // dtype, mask, 8 act, 8 wgt, sum, exp
    localparam int TIMEOUT_CYC = 40 * N_VEC + 200;
    localparam int STALL_CYC   = 30;  // out ready held low after reset

    logic                                i_clk;
    logic                                i_reset;
    logic                                i_in_valid;
    logic                                o_in_ready;
    mac_fmt_pkg::mac_dtype_e             i_dtype;
    logic [`MAC_N_ELEM-1:0]              i_mask;
    logic [`MAC_N_ELEM*`MAC_W_ELEM-1:0]  i_act;
    logic [`MAC_N_ELEM*`MAC_W_ELEM-1:0]  i_wgt;
    logic                                o_out_valid;
    logic                                i_out_ready;
    logic signed [`MAC_W_SUM-1:0]        o_sum;
    mac_fmt_pkg::mac_pexp_t              o_exp;

    logic [31:0]           pat_mem [N_VEC*N_WORD];
    logic [`MAC_W_SUM-1:0] want_sum_q [$];
    logic [`MAC_W_EXP:0]   want_exp_q [$];
    int                    want_idx_q [$];
    int                    cycle_cnt = 0;
    int                    rcv_cnt   = 0;
    bit                    saw_stall = 1'b0;

    mac_lane_top mac_lane_top_inst (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_in_valid  (i_in_valid),
        .o_in_ready  (o_in_ready),
        .i_dtype     (i_dtype),
        .i_mask      (i_mask),
        .i_act       (i_act),
        .i_wgt       (i_wgt),
        .o_out_valid (o_out_valid),
        .i_out_ready (i_out_ready),
        .o_sum       (o_sum),
        .o_exp       (o_exp)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    task automatic mismatch_stop(input string test, input logic [31:0] want,
                                 input logic [31:0] got);
        $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", test, want, got);
        $display("Simulation failed");
        $fatal(1, "wrong value on the output");
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    // put vector v on the input bus, valid high
    task automatic drive_beat(input int v);
        int base;
        base = v * N_WORD;
        i_dtype = mac_fmt_pkg::mac_dtype_e'(pat_mem[base][0]);
        i_mask  = pat_mem[base+1][`MAC_N_ELEM-1:0];
        for (int e = 0; e < `MAC_N_ELEM; e++) begin
            i_act[e*`MAC_W_ELEM +: `MAC_W_ELEM] = pat_mem[base+2+e][`MAC_W_ELEM-1:0];
            i_wgt[e*`MAC_W_ELEM +: `MAC_W_ELEM] =
                pat_mem[base+2+`MAC_N_ELEM+e][`MAC_W_ELEM-1:0];
        end
        i_in_valid = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    initial begin : stimulus
        int gap;
        int base;
        void'($urandom(32'h224b3a68));
        i_reset     = 1'b0;
        i_in_valid  = 1'b0;
        i_dtype     = mac_fmt_pkg::DT_I9;
        i_mask      = '0;
        i_act       = '0;
        i_wgt       = '0;
        i_out_ready = 1'b0;
        $readmemh("mac_lane_patterns.txt", pat_mem);
        assert (!$isunknown(pat_mem[N_VEC*N_WORD-1]))
            else abort_run("pattern file is missing or shorter than expected");

        repeat (9) @(posedge i_clk);
        @(negedge i_clk);
        assert (o_out_valid === 1'b0) else abort_run("o_out_valid is not low in reset");
        @(posedge i_clk);
        #1;
        i_reset = 1'b1;

        @(negedge i_clk);
        assert (o_out_valid === 1'b0) else abort_run("o_out_valid high after reset");
        while (o_in_ready !== 1'b1) @(negedge i_clk);
        @(posedge i_clk);
        #1;

        for (int v = 0; v < N_VEC; v++) begin
            gap = (($urandom % 4) == 0) ? 1 + ($urandom % 2) : 0;
            repeat (gap) begin
                i_in_valid = 1'b0;
                @(posedge i_clk);
                #1;
            end
            drive_beat(v);
            @(negedge i_clk);
            while (o_in_ready !== 1'b1) begin  // transfer on the next edge
                saw_stall = 1'b1;
                @(negedge i_clk);
            end
            base = v * N_WORD;
            want_sum_q.push_back(pat_mem[base+18][`MAC_W_SUM-1:0]);
            want_exp_q.push_back(pat_mem[base+19][`MAC_W_EXP:0]);
            want_idx_q.push_back(v);
            @(posedge i_clk);
            #1;
        end
        i_in_valid = 1'b0;

        while (rcv_cnt < N_VEC) @(negedge i_clk);
        repeat (10) begin
            @(negedge i_clk);
            assert (o_out_valid === 1'b0) else abort_run("extra output beat after the last one");
        end
        assert (saw_stall) else abort_run("o_in_ready never dropped under back-pressure");
        $display("Simulation passed");
        $finish;
    end

    // full stall first so the FIFO and all stages fill up
    initial begin : out_ready_drive
        @(posedge i_reset);
        repeat (STALL_CYC) @(posedge i_clk);
        forever begin
            #1;
            i_out_ready = ($urandom % 3) != 0;
            @(posedge i_clk);
        end
    end

    ////////////////////////////////////////////////////////////
    // output check, mid-cycle while everything is settled
    always @(negedge i_clk) begin : check_output
        string                 tag;
        logic [`MAC_W_SUM-1:0] want_sum;
        logic [`MAC_W_EXP:0]   want_exp;
        int                    idx;
        if (i_reset === 1'b1 && o_out_valid === 1'b1 && i_out_ready === 1'b1) begin
            assert (want_sum_q.size() != 0)
                else abort_run("output beat arrived with no input beat pending");
            want_sum = want_sum_q.pop_front();
            want_exp = want_exp_q.pop_front();
            idx      = want_idx_q.pop_front();
            tag = $sformatf("vector %0d sum", idx);
            assert (o_sum === want_sum)
                else mismatch_stop(tag, 32'(want_sum), {{(32-`MAC_W_SUM){1'b0}}, o_sum});
            tag = $sformatf("vector %0d exp", idx);
            assert (o_exp === want_exp)
                else mismatch_stop(tag, 32'(want_exp), 32'(o_exp));
            rcv_cnt++;
        end
    end

    always @(posedge i_clk) begin : watchdog
        cycle_cnt++;
        assert (cycle_cnt < TIMEOUT_CYC)
            else abort_run("timeout, not all output beats arrived in time");
    end

endmodule

`default_nettype wire
